//--- mpeg_sys_reader.f
+incdir+dv
hdl/mpeg_sys_pkg.sv
hdl/start_code_finder.sv
hdl/pes_header_parser.sv
hdl/time_stamp_reader.sv
hdl/payload_emitter.sv
hdl/mpeg_sys_reader.sv
dv/mpeg_sys_reader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mpeg_sys_reader testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module mpeg_sys_reader_tb \
   -f mpeg_sys_reader.f \
   -o mpeg_sys_reader_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/mpeg_sys_reader_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- dv/stream_model.svh
`ifndef stream_model_svh
`define stream_model_svh

// ts_kind 0 is no timestamp, 1 pts, 2 pts and dts

function automatic logic [7:0] pay_byte(input logic [7:0] id, input int i);
   return id ^ 8'(i * 37 + 11);
endfunction

task automatic put_byte(input logic [7:0] b);
   stream_q.push_back(b);
   restart_q.push_back(1'b0);
endtask

// lead, then 8 + 7 + 8 + 7 bits, marker in bit 7
task automatic put_timestamp(input logic [3:0] code, input logic [vw-1:0] ts);
   put_byte({1'b0, ts[32:30], code});
   put_byte(ts[29:22]);
   put_byte({1'b1, ts[21:15]});
   put_byte(ts[14:7]);
   put_byte({1'b1, ts[6:0]});
endtask

function automatic void expect_event(input logic [2:0] kind, input logic [vw-1:0] val,
                                     input logic [7:0] id);
   exp_kind.push_back(kind);
   exp_val.push_back(val);
   exp_id.push_back(id);
endfunction

// what the reader should deliver for one packet
function automatic void model_packet(input logic [7:0] id, input int n_stuff,
                                     input bit with_std, input int ts_kind,
                                     input logic [vw-1:0] pts_v, input logic [vw-1:0] dts_v,
                                     input int len);
   int hdr;
   if (id != mpeg_sys_pkg::private_stream_2 && n_stuff > max_stuffing)
      expect_event(ev_sync, '0, id); // dropped packet gives nothing else
   else
   begin
      if (id == mpeg_sys_pkg::private_stream_2)
         hdr = 0;
      else
         hdr = n_stuff + (with_std ? 2 : 0) + ((ts_kind == 0) ? 1 : 5 * ts_kind);
      if (id != mpeg_sys_pkg::private_stream_2 && ts_kind > 0)
         expect_event(ev_pts, pts_v, id);
      if (id != mpeg_sys_pkg::private_stream_2 && ts_kind > 1)
         expect_event(ev_dts, dts_v, id);
      for (int i = 0; i < len - hdr; i++)
         expect_event(ev_payload, vw'(pay_byte(id, i)), id);
   end
endfunction

task automatic add_packet(input logic [7:0] id, input int n_stuff, input bit with_std,
                          input int ts_kind, input logic [vw-1:0] pts_v,
                          input logic [vw-1:0] dts_v, input int len);
   int start_at;
   bit dropped;
   dropped = 1'b0;
   put_byte(8'h00);
   put_byte(8'h00);
   put_byte(8'h01);
   put_byte(id);
   put_byte(len[15:8]);
   put_byte(len[7:0]);
   start_at = stream_q.size();
   if (id != mpeg_sys_pkg::private_stream_2)
   begin
      repeat (n_stuff)
         put_byte(mpeg_sys_pkg::stuffing_byte);
      dropped = (n_stuff > max_stuffing);
      if (with_std && !dropped)
      begin
         put_byte(8'h5D); // tag 01, scale 1
         put_byte(8'h20);
      end
      if (!dropped)
      begin
         case (ts_kind)
            0: put_byte(mpeg_sys_pkg::no_ts_byte);
            1: put_timestamp(4'b0010, pts_v);
            default:
            begin
               put_timestamp(4'b0011, pts_v);
               put_timestamp(4'b0001, dts_v);
            end
         endcase
      end
   end
   for (int i = 0; !dropped && (stream_q.size() - start_at < len); i++)
      put_byte(pay_byte(id, i));
   model_packet(id, n_stuff, with_std, ts_kind, pts_v, dts_v, len);
endtask

task automatic scatter_junk(input int n);
   repeat (n)
      put_byte(8'($urandom_range(1, 254))); // never 00, never stuffing
endtask

task automatic false_prefix();
   put_byte(8'h00);
   put_byte(8'h00);
   put_byte(8'h02);
endtask

task automatic send_code(input logic [7:0] code);
   put_byte(8'h00);
   put_byte(8'h00);
   put_byte(8'h01);
   put_byte(code);
   restart_q[restart_q.size() - 1] = (code == mpeg_sys_pkg::pack_start_code);
   expect_event(ev_done, vw'(code == mpeg_sys_pkg::end_code), code);
endtask

`endif

//--- dv/mpeg_sys_reader_tb.sv
`timescale 1ns/1ps

module mpeg_sys_reader_tb;

   localparam int max_stuffing = 6;
   localparam int vw           = mpeg_sys_pkg::ts_w;

   localparam logic [2:0] ev_payload = 3'd0;
   localparam logic [2:0] ev_pts     = 3'd1;
   localparam logic [2:0] ev_dts     = 3'd2;
   localparam logic [2:0] ev_sync    = 3'd3;
   localparam logic [2:0] ev_done    = 3'd4;

   logic          read_signal;
   logic          arst_n;
   logic          start;
   logic [7:0]    byte_in;
   logic          byte_valid;
   logic          done;
   logic          stream_done;
   logic [7:0]    payload;
   logic          payload_valid;
   logic [7:0]    payload_id;
   logic [vw-1:0] pts;
   logic [vw-1:0] dts;
   logic          pts_valid;
   logic          dts_valid;
   logic          sync_error;

   logic [7:0]    stream_q[$];
   bit            restart_q[$]; // wait for done and toggle start after this byte
   logic [2:0]    exp_kind[$];
   logic [vw-1:0] exp_val[$];
   logic [7:0]    exp_id[$];
   logic [7:0]    last_id;
   logic          done_q;
   int            cycles      = 0;
   int            cycle_limit = 1000000;

   `include "stream_model.svh"

   mpeg_sys_reader #(.max_stuffing(max_stuffing)) i_dut
   (
      .read_signal   (read_signal),
      .arst_n        (arst_n),
      .start         (start),
      .byte_in       (byte_in),
      .byte_valid    (byte_valid),
      .done          (done),
      .stream_done   (stream_done),
      .payload       (payload),
      .payload_valid (payload_valid),
      .payload_id    (payload_id),
      .pts           (pts),
      .dts           (dts),
      .pts_valid     (pts_valid),
      .dts_valid     (dts_valid),
      .sync_error    (sync_error)
   );

   initial
   begin
      read_signal = 1'b0;
      forever
         #50 read_signal = ~read_signal;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [vw-1:0] got,
                              input logic [vw-1:0] expected);
      if (got !== expected)
      begin
         $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, expected);
         stop_with_failure("output value mismatch");
      end
   endtask

   task automatic match_event(input string name, input logic [2:0] kind,
                              input logic [vw-1:0] got);
      logic [vw-1:0] want;
      if (exp_kind.size() == 0)
         stop_with_failure($sformatf("%s rose at %0d ns with no result left to expect",
                                     name, $time));
      else if (exp_kind[0] != kind)
         stop_with_failure($sformatf("%s rose at %0d ns but another result was due first",
                                     name, $time));
      else
      begin
         want    = exp_val.pop_front();
         last_id = exp_id.pop_front();
         exp_kind.delete(0);
         check_value(name, got, want);
      end
   endtask

   task automatic restart_reader();
      byte_valid <= 1'b0;
      @(negedge read_signal);
      while (!done)
         @(negedge read_signal);
      @(posedge read_signal);
      start <= 1'b0;
      @(negedge read_signal);
      while (done)
         @(negedge read_signal);
      @(posedge read_signal);
      start <= 1'b1;
   endtask

   task automatic build_stream();
      scatter_junk(5);
      add_packet(mpeg_sys_pkg::private_stream_2, 0, 1'b0, 0, '0, '0, 12);
      false_prefix();
      scatter_junk(3);
      add_packet(8'hE0, 3, 1'b1, 1, 33'h1_2345_6789, '0, 20); // stuffing, std, pts
      add_packet(8'hC0, 0, 1'b0, 2, 33'h0_ABCD_EF01, 33'h0_ABCD_0123, 18);
      false_prefix();
      add_packet(8'hC1, max_stuffing, 1'b0, 0, '0, '0, 10); // right at the limit
      send_code(mpeg_sys_pkg::pack_start_code);
      scatter_junk(8); // pack header body
      add_packet(8'hE1, max_stuffing + 1, 1'b0, 1, '0, '0, 30);
      add_packet(8'hE2, 0, 1'b1, 1, 33'h1_FFFF_FFFE, '0, 7); // header fills the length
      scatter_junk(2);
      add_packet(mpeg_sys_pkg::private_stream_2, 0, 1'b0, 0, '0, '0, 3);
      send_code(mpeg_sys_pkg::end_code);
   endtask

   // stimulus
   initial
   begin
      int gap;
      void'($urandom(83686));
      arst_n     = 1'b0;
      start      = 1'b0;
      byte_in    = 8'h00;
      byte_valid = 1'b0;
      build_stream();
      cycle_limit = 3 * stream_q.size() + 50;
      repeat (2)
         @(posedge read_signal);
      arst_n <= 1'b1;
      start  <= 1'b1;
      for (int i = 0; i < stream_q.size(); i++)
      begin
         if ($urandom_range(0, 3) == 0)
         begin
            gap = $urandom_range(1, 3);
            repeat (gap)
            begin
               byte_valid <= 1'b0;
               byte_in    <= 8'($urandom); // ignored while invalid
               @(posedge read_signal);
            end
         end
         byte_in    <= stream_q[i];
         byte_valid <= 1'b1;
         @(posedge read_signal);
         if (restart_q[i])
            restart_reader();
      end
      byte_valid <= 1'b0;
      while (exp_kind.size() != 0)
         @(posedge read_signal);
      repeat (4)
         @(negedge read_signal); // room for stray outputs
      if (stream_done)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
         stop_with_failure("stream_done low at the end of the run");
   end

   // compare
   initial
   begin
      done_q = 1'b0;
      @(posedge arst_n);
      @(negedge read_signal);
      check_value("done", vw'(done), '0);
      check_value("stream_done", vw'(stream_done), '0);
      check_value("payload_valid", vw'(payload_valid), '0);
      check_value("pts_valid", vw'(pts_valid), '0);
      check_value("dts_valid", vw'(dts_valid), '0);
      check_value("sync_error", vw'(sync_error), '0);
      forever
      begin
         @(negedge read_signal);
         if (pts_valid)
            match_event("pts", ev_pts, pts);
         if (dts_valid)
            match_event("dts", ev_dts, dts);
         if (payload_valid)
         begin
            match_event("payload", ev_payload, vw'(payload));
            check_value("payload_id", vw'(payload_id), vw'(last_id));
         end
         if (sync_error)
            match_event("sync_error", ev_sync, '0);
         if (done && !done_q)
            match_event("stream_done", ev_done, vw'(stream_done));
         done_q = done;
      end
   end

   always @(posedge read_signal)
   begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit)
         stop_with_failure("timeout, the stream was not fully processed in time");
   end

endmodule

//--- hdl/mpeg_sys_reader.sv
`timescale 1ns/1ps

module mpeg_sys_reader
#(
   parameter int max_stuffing = 16
)
(
   input  logic                          read_signal,
   input  logic                          arst_n,
   input  logic                          start,
   input  logic [7:0]                    byte_in,
   input  logic                          byte_valid,
   output logic                          done,
   output logic                          stream_done,
   output logic [7:0]                    payload,
   output logic                          payload_valid,
   output logic [7:0]                    payload_id,
   output logic [mpeg_sys_pkg::ts_w-1:0] pts,
   output logic [mpeg_sys_pkg::ts_w-1:0] dts,
   output logic                          pts_valid,
   output logic                          dts_valid,
   output logic                          sync_error
);

   logic        hunt;
   logic        prefix_found;
   logic        ts_go;
   logic        ts_done;
   logic [3:0]  ts_len;
   logic        pay_go;
   logic [15:0] pay_count;
   logic        pay_end;
   logic [7:0]  stream_id;

   start_code_finder u_finder
   (
      .read_signal  (read_signal),
      .arst_n       (arst_n),
      .start        (start),
      .hunt         (hunt),
      .byte_in      (byte_in),
      .byte_valid   (byte_valid),
      .prefix_found (prefix_found)
   );

   pes_header_parser #(.max_stuffing(max_stuffing)) u_parser
   (
      .read_signal  (read_signal),
      .arst_n       (arst_n),
      .start        (start),
      .byte_in      (byte_in),
      .byte_valid   (byte_valid),
      .prefix_found (prefix_found),
      .ts_done      (ts_done),
      .ts_len       (ts_len),
      .pay_end      (pay_end),
      .hunt         (hunt),
      .done         (done),
      .stream_done  (stream_done),
      .ts_go        (ts_go),
      .pay_go       (pay_go),
      .pay_count    (pay_count),
      .stream_id    (stream_id),
      .sync_error   (sync_error)
   );

   time_stamp_reader u_ts_reader
   (
      .read_signal (read_signal),
      .arst_n      (arst_n),
      .byte_in     (byte_in),
      .byte_valid  (byte_valid),
      .ts_go       (ts_go),
      .ts_done     (ts_done),
      .ts_len      (ts_len),
      .pts         (pts),
      .dts         (dts),
      .pts_valid   (pts_valid),
      .dts_valid   (dts_valid)
   );

   payload_emitter u_emitter
   (
      .read_signal   (read_signal),
      .arst_n        (arst_n),
      .byte_in       (byte_in),
      .byte_valid    (byte_valid),
      .pay_go        (pay_go),
      .pay_count     (pay_count),
      .stream_id     (stream_id),
      .pay_end       (pay_end),
      .payload       (payload),
      .payload_valid (payload_valid),
      .payload_id    (payload_id)
   );

endmodule

//--- hdl/payload_emitter.sv
`timescale 1ns/1ps

module payload_emitter
(
   input  logic        read_signal,
   input  logic        arst_n,
   input  logic [7:0]  byte_in,
   input  logic        byte_valid,
   input  logic        pay_go,
   input  logic [15:0] pay_count,
   input  logic [7:0]  stream_id,
   output logic        pay_end,
   output logic [7:0]  payload,
   output logic        payload_valid,
   output logic [7:0]  payload_id
);

   logic [15:0] count; // payload bytes still to pass
   logic        take;

   assign take    = byte_valid & (count != 16'd0);
   assign pay_end = take & (count == 16'd1);

   always_ff @(posedge read_signal or negedge arst_n)
   begin
      if (!arst_n)
      begin
         count         <= 16'd0;
         payload_valid <= 1'b0;
      end
      else
      begin
         payload_valid <= take;
         if (pay_go)
            count <= pay_count;
         else if (take)
            count <= count - 16'd1;
      end
   end

   always_ff @(posedge read_signal)
   begin
      if (take)
      begin
         payload    <= byte_in;
         payload_id <= stream_id;
      end
   end

endmodule

//--- hdl/time_stamp_reader.sv
`timescale 1ns/1ps

module time_stamp_reader
(
   input  logic                          read_signal,
   input  logic                          arst_n,
   input  logic [7:0]                    byte_in,
   input  logic                          byte_valid,
   input  logic                          ts_go,
   output logic                          ts_done,
   output logic [3:0]                    ts_len,
   output logic [mpeg_sys_pkg::ts_w-1:0] pts,
   output logic [mpeg_sys_pkg::ts_w-1:0] dts,
   output logic                          pts_valid,
   output logic                          dts_valid
);

   mpeg_sys_pkg::header_lead_u lead;
   logic [3:0]                 cnt;      // byte position after the lead
   logic                       busy;
   logic                       with_dts;
   logic                       lead_none;
   logic                       last_byte;

   assign lead      = byte_in;
   assign lead_none = ts_go & (byte_in == mpeg_sys_pkg::no_ts_byte);
   assign last_byte = busy & byte_valid & ((cnt == 4'd9) | ((cnt == 4'd4) & ~with_dts));
   assign ts_done   = lead_none | last_byte;
   assign ts_len    = lead_none ? 4'd1 : (with_dts ? 4'd10 : 4'd5);

   always_ff @(posedge read_signal or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cnt       <= 4'd0;
         busy      <= 1'b0;
         with_dts  <= 1'b0;
         pts_valid <= 1'b0;
         dts_valid <= 1'b0;
      end
      else
      begin
         pts_valid <= 1'b0;
         dts_valid <= 1'b0;
         if (ts_go && !lead_none)
         begin
            busy     <= 1'b1;
            cnt      <= 4'd1;
            with_dts <= (lead.as_ts.ts_code == 4'b0011);
         end
         else if (busy && byte_valid)
         begin
            cnt       <= cnt + 4'd1;
            pts_valid <= (cnt == 4'd4);
            dts_valid <= (cnt == 4'd9);
            if (last_byte)
               busy <= 1'b0;
         end
      end
   end

   // marker bits in bit 7 of the 7-bit groups are dropped
   always_ff @(posedge read_signal)
   begin
      if (ts_go && !lead_none)
         pts[32:30] <= lead.as_ts.ts_top;
      else if (busy && byte_valid)
      begin
         case (cnt)
            4'd1: pts[29:22] <= byte_in;
            4'd2: pts[21:15] <= byte_in[6:0];
            4'd3: pts[14:7]  <= byte_in;
            4'd4: pts[6:0]   <= byte_in[6:0];
            4'd5: dts[32:30] <= lead.as_ts.ts_top; // dts lead
            4'd6: dts[29:22] <= byte_in;
            4'd7: dts[21:15] <= byte_in[6:0];
            4'd8: dts[14:7]  <= byte_in;
            4'd9: dts[6:0]   <= byte_in[6:0];
            default: ;
         endcase
      end
   end

endmodule

//--- hdl/pes_header_parser.sv
`timescale 1ns/1ps

module pes_header_parser
#(
   parameter int max_stuffing = 16
)
(
   input  logic        read_signal,
   input  logic        arst_n,
   input  logic        start,
   input  logic [7:0]  byte_in,
   input  logic        byte_valid,
   input  logic        prefix_found,
   input  logic        ts_done,
   input  logic [3:0]  ts_len,
   input  logic        pay_end,
   output logic        hunt,
   output logic        done,
   output logic        stream_done,
   output logic        ts_go,
   output logic        pay_go,
   output logic [15:0] pay_count,
   output logic [7:0]  stream_id,
   output logic        sync_error
);

   localparam int cnt_w = $clog2(max_stuffing + 2);
   localparam logic [cnt_w-1:0] max_cnt = cnt_w'(max_stuffing);

   typedef enum logic [3:0]
   {
      s_hunt,
      s_len_hi,
      s_len_lo,
      s_lead,
      s_std_lo,
      s_ts_lead,
      s_ts_wait,
      s_payload,
      s_done
   } state_t;

   state_t                    state;
   state_t                    ts_next;
   logic [15:0]               remain;    // packet bytes not yet consumed
   logic [15:0]               len_full;
   logic [15:0]               ts_rem;
   logic [cnt_w-1:0]          stuff_cnt;
   mpeg_sys_pkg::header_lead_u lead;
   logic                      is_stuff;
   logic                      is_std;
   logic                      is_ts;
   logic                      psb2_end;

   assign lead     = byte_in;
   assign len_full = {remain[15:8], byte_in};
   assign ts_rem   = remain - {12'd0, ts_len};
   assign is_stuff = (byte_in == mpeg_sys_pkg::stuffing_byte);
   assign is_std   = (lead.as_std.tag == 2'b01);
   assign is_ts    = (byte_in == mpeg_sys_pkg::no_ts_byte) ||
                     (lead.as_ts.ts_code == 4'b0010) ||
                     (lead.as_ts.ts_code == 4'b0011);
   assign hunt     = (state == s_hunt);

   // lead byte goes to the timestamp reader in the same cycle
   assign ts_go = byte_valid & is_ts &
                  (((state == s_lead) & ~is_stuff & ~is_std) | (state == s_ts_lead));

   assign psb2_end  = byte_valid & (state == s_len_lo) &
                      (stream_id == mpeg_sys_pkg::private_stream_2);
   assign pay_go    = (ts_done & (ts_rem != 16'd0)) | (psb2_end & (len_full != 16'd0));
   assign pay_count = psb2_end ? len_full : ts_rem;
   assign ts_next   = !ts_done ? s_ts_wait : ((ts_rem == 16'd0) ? s_hunt : s_payload);

   always_ff @(posedge read_signal or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state       <= s_hunt;
         done        <= 1'b0;
         stream_done <= 1'b0;
         sync_error  <= 1'b0;
         stuff_cnt   <= '0;
         remain      <= 16'd0;
         stream_id   <= 8'd0;
      end
      else
      begin
         sync_error <= 1'b0;
         if (state == s_done)
         begin
            if (!start)
            begin
               done  <= 1'b0;
               state <= s_hunt;
            end
         end
         else if (byte_valid)
         begin
            case (state)
               s_hunt:
                  if (prefix_found)
                  begin
                     if (byte_in == mpeg_sys_pkg::pack_start_code ||
                         byte_in == mpeg_sys_pkg::end_code)
                     begin
                        done        <= 1'b1;
                        stream_done <= stream_done | (byte_in == mpeg_sys_pkg::end_code);
                        state       <= s_done;
                     end
                     else
                     begin
                        stream_id <= byte_in;
                        stuff_cnt <= '0;
                        state     <= s_len_hi;
                     end
                  end
               s_len_hi:
               begin
                  remain[15:8] <= byte_in;
                  state        <= s_len_lo;
               end
               s_len_lo:
               begin
                  remain <= len_full;
                  if (stream_id == mpeg_sys_pkg::private_stream_2)
                     state <= (len_full == 16'd0) ? s_hunt : s_payload;
                  else
                     state <= s_lead;
               end
               s_lead:
                  if (is_stuff)
                  begin
                     if (stuff_cnt == max_cnt)
                     begin
                        sync_error <= 1'b1; // drop the packet
                        state      <= s_hunt;
                     end
                     else
                     begin
                        stuff_cnt <= stuff_cnt + cnt_w'(1);
                        remain    <= remain - 16'd1;
                     end
                  end
                  else if (is_std)
                  begin
                     remain <= remain - 16'd1;
                     state  <= s_std_lo;
                  end
                  else if (!is_ts)
                  begin
                     sync_error <= 1'b1;
                     state      <= s_hunt;
                  end
                  else
                     state <= ts_next;
               s_std_lo:
               begin
                  remain <= remain - 16'd1;
                  state  <= s_ts_lead;
               end
               s_ts_lead:
                  if (!is_ts)
                  begin
                     sync_error <= 1'b1;
                     state      <= s_hunt;
                  end
                  else
                     state <= ts_next;
               s_ts_wait:
                  if (ts_done)
                     state <= ts_next;
               s_payload:
                  if (pay_end)
                     state <= s_hunt;
               default:
                  state <= s_hunt;
            endcase
         end
      end
   end

endmodule

//--- hdl/start_code_finder.sv
`timescale 1ns/1ps

module start_code_finder
(
   input  logic       read_signal,
   input  logic       arst_n,
   input  logic       start,
   input  logic       hunt,
   input  logic [7:0] byte_in,
   input  logic       byte_valid,
   output logic       prefix_found
);

   typedef enum logic [1:0]
   {
      z_none,
      z_one,
      z_two
   } zero_state_t;

   zero_state_t zeros;
   logic        searching;

   assign searching = start & hunt;

   always_ff @(posedge read_signal or negedge arst_n)
   begin
      if (!arst_n)
      begin
         zeros        <= z_none;
         prefix_found <= 1'b0;
      end
      else if (byte_valid)
      begin
         prefix_found <= 1'b0; // held over stalls until the code byte
         if (!searching)
            zeros <= z_none;
         else
         begin
            case (zeros)
               z_none:
                  if (byte_in == 8'h00)
                     zeros <= z_one;
               z_one:
                  zeros <= (byte_in == 8'h00) ? z_two : z_none;
               z_two:
               begin
                  if (byte_in == 8'h01)
                  begin
                     prefix_found <= 1'b1;
                     zeros        <= z_none;
                  end
                  else if (byte_in != 8'h00)
                     zeros <= z_none; // extra zeros stay in z_two
               end
               default:
                  zeros <= z_none;
            endcase
         end
      end
   end

endmodule

//--- hdl/mpeg_sys_pkg.sv
package mpeg_sys_pkg;

   // code bytes that follow the 00 00 01 prefix
   localparam logic [7:0] pack_start_code  = 8'hBA;
   localparam logic [7:0] end_code         = 8'hB9;
   localparam logic [7:0] private_stream_2 = 8'hBF; // no header extension

   localparam logic [7:0] stuffing_byte = 8'hFF;
   localparam logic [7:0] no_ts_byte    = 8'h0F;

   localparam int ts_w = 33;

   // first byte after stuffing, read as an STD buffer field
   typedef struct packed
   {
      logic [4:0] size_hi;
      logic       scale;
      logic [1:0] tag;     // 01 marks an STD field
   } std_lead_t;

   // same byte, read as a timestamp lead
   typedef struct packed
   {
      logic       spare;
      logic [2:0] ts_top;  // timestamp bits 32:30
      logic [3:0] ts_code; // 0010 pts, 0011 pts and dts
   } ts_lead_t;

   typedef union packed
   {
      std_lead_t as_std;
      ts_lead_t  as_ts;
   } header_lead_u;

endpackage
